/* design/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // cache geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_WIDTH   = 5;
    localparam int INDEX_WIDTH    = 7;
    localparam int TAG_WIDTH      = 20;
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 1 << INDEX_WIDTH;

    // byte address and data word
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [WORD_WIDTH/8-1:0] strb_t;

    // address fields
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // one full line, word 0 in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

endpackage

/* design/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL
    } ctrl_state_t;

    // index of the final beat of a line burst
    localparam cache_cfg_pkg::word_sel_t BURST_LAST =
        cache_cfg_pkg::word_sel_t'(cache_cfg_pkg::WORDS_PER_LINE - 1);

endpackage

/* design/cache_array_if.sv */
`timescale 1ns/1ps

interface cache_array_if;
    import cache_cfg_pkg::*;

    // request side
    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;

    // store and refill writes
    logic      store_we;
    word_t     store_data;
    strb_t     store_strb;
    logic      refill_we;
    word_t     refill_word;
    logic      fill_done;
    logic      fill_dirty;
    word_sel_t wb_word_sel;

    // lookup results
    logic      hit;
    word_t     load_word;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    word_t     victim_word;

    modport ctrl (
        output index, tag, word_sel,
        output store_we, store_data, store_strb,
        output refill_we, fill_done, fill_dirty, wb_word_sel,
        input  hit, victim_way, victim_dirty, victim_tag
    );

    modport arrays (
        input  index, tag, word_sel,
        input  store_we, store_data, store_strb,
        input  refill_we, refill_word, fill_done, fill_dirty, wb_word_sel,
        output hit, load_word, victim_way, victim_dirty, victim_tag, victim_word
    );

endinterface

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req,
    input  logic                     we,
    input  cache_cfg_pkg::addr_t     addr,
    input  cache_cfg_pkg::word_t     wdata,
    input  cache_cfg_pkg::strb_t     wstrb,
    output logic                     ready,
    output logic                     resp_valid,
    output logic                     mem_rd_req,
    output logic                     mem_wvalid,
    output cache_cfg_pkg::addr_t     mem_rd_addr,
    output cache_cfg_pkg::addr_t     mem_wr_addr,
    input  logic                     mem_rvalid,
    input  cache_cfg_pkg::word_sel_t beat,
    input  logic                     last,
    output logic                     cnt_clear,
    output logic                     cnt_step,
    cache_array_if.ctrl              cif
);
    import cache_cfg_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    addr_t     req_addr_q;
    logic      req_we_q;
    word_t     req_wdata_q;
    strb_t     req_strb_q;

    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;

    logic      wb_issue;
    logic      wb_issued_q;
    logic      wb_valid_q;

    assign req_tag   = req_addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index = req_addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_word  = req_addr_q[OFFSET_WIDTH-1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            req_addr_q  <= '0;
            req_we_q    <= 1'b0;
            wb_issued_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            state <= state_next;
            if (ready && req) begin
                req_addr_q <= addr;
                req_we_q   <= we;
            end
            // word read in one cycle goes out on the bus in the next
            wb_valid_q <= wb_issue;
            if (state != ST_WRITEBACK) begin
                wb_issued_q <= 1'b0;
            end else if (wb_issue && last) begin
                wb_issued_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready && req) begin
            req_wdata_q <= wdata;
            req_strb_q  <= wstrb;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_next = ST_COMPARE;
            end
            ST_COMPARE: begin
                if (cif.hit) begin
                    state_next = ST_IDLE;
                end else if (cif.victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                if (wb_issued_q) begin
                    state_next = ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                state_next = ST_REFILL;
            end
            ST_REFILL: begin
                // back to lookup so the retried access hits
                if (mem_rvalid && last) begin
                    state_next = ST_LOOKUP;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign ready       = (state == ST_IDLE);
    assign resp_valid  = (state == ST_COMPARE) && cif.hit;
    assign wb_issue    = (state == ST_WRITEBACK) && !wb_issued_q;
    assign mem_wvalid  = wb_valid_q;
    assign mem_rd_req  = (state == ST_REFILL);
    assign mem_rd_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign mem_wr_addr = {cif.victim_tag, req_index, {OFFSET_WIDTH{1'b0}}};

    assign cnt_clear = ((state == ST_COMPARE) && !cif.hit) || (state == ST_REFILL_REQ);
    assign cnt_step  = wb_issue || (mem_rd_req && mem_rvalid);

    assign cif.index       = req_index;
    assign cif.tag         = req_tag;
    assign cif.word_sel    = (state == ST_REFILL) ? beat : req_word;
    assign cif.wb_word_sel = beat;
    // every hit goes through the store port; loads carry no strobes
    assign cif.store_we    = resp_valid;
    assign cif.store_data  = req_wdata_q;
    assign cif.store_strb  = req_we_q ? req_strb_q : '0;
    assign cif.refill_we   = mem_rd_req && mem_rvalid;
    assign cif.fill_done   = cif.refill_we && last;
    assign cif.fill_dirty  = req_we_q;

    // refill and writeback never share the memory side
    assert property (@(posedge clk) disable iff (!arst_n) !(mem_rd_req && mem_wvalid));

    // victim chosen at compare holds until the fill lands
    assert property (@(posedge clk) disable iff (!arst_n)
        state inside {ST_WRITEBACK, ST_REFILL_REQ, ST_REFILL} |=> $stable(cif.victim_way));

endmodule

/* design/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear,
    input  logic                     step,
    output cache_cfg_pkg::word_sel_t beat,
    output logic                     last
);
    import cache_ctrl_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat <= '0;
        end else if (clear) begin
            beat <= '0;
        end else if (step) begin
            beat <= beat + 1'b1;
        end
    end

    assign last = (beat == BURST_LAST);

    // a burst ends on its last step, the next one starts after a clear
    assert property (@(posedge clk) disable iff (!arst_n)
        last && step && !clear |=> !step || clear);

endmodule

/* design/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays (
    input logic           clk,
    input logic           arst_n,
    cache_array_if.arrays arr
);
    import cache_cfg_pkg::*;

    // storage
    line_t data_mem [NUM_WAYS][NUM_SETS];
    tag_t  tag_mem  [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_bits;
    // way to replace next in each set
    logic [NUM_SETS-1:0] lru_bits;

    // registered read of the current set
    line_t rd_line_q [NUM_WAYS];
    tag_t  rd_tag_q  [NUM_WAYS];
    logic [NUM_WAYS-1:0] rd_valid_q;
    logic [NUM_WAYS-1:0] rd_dirty_q;
    way_t  rd_lru_q;
    word_t wb_word_q;

    logic [NUM_WAYS-1:0] way_hit;
    way_t  hit_way;
    word_t store_merged;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_line_q[w] <= data_mem[w][arr.index];
            rd_tag_q[w]  <= tag_mem[w][arr.index];
        end
        wb_word_q <= data_mem[rd_lru_q][arr.index][arr.wb_word_sel];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= '0;
            rd_dirty_q <= '0;
            rd_lru_q   <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_valid_q[w] <= valid_bits[w][arr.index];
                rd_dirty_q[w] <= dirty_bits[w][arr.index];
            end
            rd_lru_q <= lru_bits[arr.index];
        end
    end

    // hit compare
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_valid_q[w] && (rd_tag_q[w] == arr.tag);
        end
    end

    assign hit_way       = way_hit[1];
    assign arr.hit       = |way_hit;
    assign arr.load_word = rd_line_q[hit_way][arr.word_sel];

    // byte merge of a store into the word just read
    always_comb begin
        store_merged = arr.load_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (arr.store_strb[b]) begin
                store_merged[8*b +: 8] = arr.store_data[8*b +: 8];
            end
        end
    end

    assign arr.victim_way   = rd_lru_q;
    assign arr.victim_dirty = rd_valid_q[rd_lru_q] && rd_dirty_q[rd_lru_q];
    assign arr.victim_tag   = rd_tag_q[rd_lru_q];
    assign arr.victim_word  = wb_word_q;

    always_ff @(posedge clk) begin
        if (arr.store_we && (|arr.store_strb)) begin
            data_mem[hit_way][arr.index][arr.word_sel] <= store_merged;
        end else if (arr.refill_we) begin
            data_mem[rd_lru_q][arr.index][arr.word_sel] <= arr.refill_word;
        end
        if (arr.fill_done) begin
            tag_mem[rd_lru_q][arr.index] <= arr.tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end else if (arr.store_we) begin
            if (|arr.store_strb) begin
                dirty_bits[hit_way][arr.index] <= 1'b1;
            end
            lru_bits[arr.index] <= ~hit_way;
        end else if (arr.fill_done) begin
            valid_bits[rd_lru_q][arr.index] <= 1'b1;
            dirty_bits[rd_lru_q][arr.index] <= arr.fill_dirty;
            lru_bits[arr.index]             <= ~rd_lru_q;
        end
    end

    // a line is only filled after a miss, so it never sits in both ways
    assert property (@(posedge clk) disable iff (!arst_n) !(way_hit[0] && way_hit[1]));

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // core side
    input  logic                 req,
    input  logic                 we,
    input  cache_cfg_pkg::addr_t addr,
    input  cache_cfg_pkg::word_t wdata,
    input  cache_cfg_pkg::strb_t wstrb,
    output logic                 ready,
    output logic                 resp_valid,
    output cache_cfg_pkg::word_t rdata,
    // memory side
    output logic                 mem_rd_req,
    output cache_cfg_pkg::addr_t mem_rd_addr,
    output logic                 mem_wvalid,
    output cache_cfg_pkg::addr_t mem_wr_addr,
    output cache_cfg_pkg::word_t mem_wdata,
    input  logic                 mem_rvalid,
    input  cache_cfg_pkg::word_t mem_rdata
);
    import cache_cfg_pkg::*;

    word_sel_t beat;
    logic      last;
    logic      cnt_clear;
    logic      cnt_step;

    cache_array_if cif ();

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .mem_rd_req  (mem_rd_req),
        .mem_wvalid  (mem_wvalid),
        .mem_rd_addr (mem_rd_addr),
        .mem_wr_addr (mem_wr_addr),
        .mem_rvalid  (mem_rvalid),
        .beat        (beat),
        .last        (last),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .cif         (cif.ctrl)
    );

    beat_counter u_beat (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (cnt_clear),
        .step   (cnt_step),
        .beat   (beat),
        .last   (last)
    );

    dcache_arrays u_arrays (
        .clk    (clk),
        .arst_n (arst_n),
        .arr    (cif.arrays)
    );

    // data paths that bypass the controller
    assign cif.refill_word = mem_rdata;
    assign rdata           = cif.load_word;
    assign mem_wdata       = cif.victim_word;

endmodule

/* tests/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import cache_cfg_pkg::*;

    localparam word_t       FILL_PATTERN = 32'ha5a5_a5a5;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic  clk = 1'b0;
    logic  arst_n;
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  ready;
    logic  resp_valid;
    word_t rdata;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_wvalid;
    addr_t mem_wr_addr;
    word_t mem_wdata;
    logic  mem_rvalid = 1'b0;
    word_t mem_rdata  = '0;

    // cases from the data file
    logic [7:0] case_op   [$];
    addr_t      case_addr [$];
    strb_t      case_strb [$];
    word_t      case_data [$];

    // reference model
    word_t ref_mem [addr_t];
    tag_t  ref_tag   [NUM_WAYS][NUM_SETS];
    logic  ref_valid [NUM_WAYS][NUM_SETS];
    logic  ref_dirty [NUM_WAYS][NUM_SETS];
    way_t  ref_lru   [NUM_SETS];

    // memory model state
    word_t       backing [addr_t];
    int          rd_beat     = 0;
    logic        rd_armed    = 1'b0;
    logic [1:0]  rd_gap      = 2'd0;
    int          wb_beat     = 0;
    logic [31:0] lfsr_state  = 32'h3cd8_425b;

    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 16;

    dcache_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .rdata       (rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_wvalid  (mem_wvalid),
        .mem_wr_addr (mem_wr_addr),
        .mem_wdata   (mem_wdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return lfsr_state[0];
    endfunction

    function automatic word_t ref_word(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ FILL_PATTERN;
    endfunction

    function automatic word_t backing_word(addr_t a);
        if (backing.exists(a)) begin
            return backing[a];
        end
        return a ^ FILL_PATTERN;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED @ %0t: %s", $time, msg);
        errors++;
    endtask

    // memory side: refill beats with random gaps, writeback capture
    always @(negedge clk) begin
        mem_rvalid <= 1'b0;
        if (mem_wvalid) begin
            backing[mem_wr_addr + addr_t'(4 * wb_beat)] = mem_wdata;
            wb_beat = wb_beat + 1;
        end else begin
            wb_beat = 0;
        end
        if (!mem_rd_req) begin
            rd_beat  = 0;
            rd_armed = 1'b0;
        end else if (rd_beat < WORDS_PER_LINE) begin
            if (!rd_armed) begin
                rd_gap   = {lfsr_bit(), lfsr_bit()};
                rd_armed = 1'b1;
            end
            if (rd_gap == 2'd0) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= backing_word(mem_rd_addr + addr_t'(4 * rd_beat));
                rd_beat  = rd_beat + 1;
                rd_armed = 1'b0;
            end else begin
                rd_gap = rd_gap - 2'd1;
            end
        end
    end

    task automatic load_cases();
        int         fd;
        int         fields;
        string      line;
        logic [7:0] op;
        addr_t      a;
        strb_t      s;
        word_t      d;

        fd = $fopen("tests/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/dcache_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h", op, a, s, d);
                    if (fields == 4) begin
                        case_op.push_back(op);
                        case_addr.push_back(a);
                        case_strb.push_back(s);
                        case_data.push_back(d);
                    end else begin
                        $display("unreadable line in case file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int n);
        logic [7:0] op;
        addr_t      a;
        addr_t      wa;
        addr_t      line_addr;
        addr_t      victim_addr;
        index_t     idx;
        tag_t       tg;
        way_t       way;
        logic       exp_hit;
        logic       exp_wb;
        logic       saw_rd;
        int         lat;
        int         wb_count;
        int         wb_first;
        int         wb_last;
        int         errors_before;
        word_t      merged;

        op            = case_op[n];
        a             = case_addr[n];
        wa            = {a[ADDR_WIDTH-1:2], 2'b00};
        line_addr     = {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        idx           = a[OFFSET_WIDTH +: INDEX_WIDTH];
        tg            = a[ADDR_WIDTH-1 -: TAG_WIDTH];
        errors_before = errors;
        if (op != "L" && op != "S") begin
            $display("case %0d has an unknown operation letter", n);
            errors++;
        end

        // expected outcome from the reference tags
        exp_hit = 1'b0;
        way     = ref_lru[idx];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tg) begin
                exp_hit = 1'b1;
                way     = way_t'(w);
            end
        end
        exp_wb      = !exp_hit && ref_valid[way][idx] && ref_dirty[way][idx];
        victim_addr = {ref_tag[way][idx], idx, {OFFSET_WIDTH{1'b0}}};

        @(negedge clk);
        if (!ready) begin
            report_mismatch($sformatf("ready low at start of case %0d", n));
        end
        req   <= 1'b1;
        we    <= (op == "S");
        addr  <= a;
        wdata <= case_data[n];
        wstrb <= case_strb[n];
        @(negedge clk);
        req      <= 1'b0;
        lat      = 1;
        saw_rd   = 1'b0;
        wb_count = 0;
        wb_first = 0;
        wb_last  = 0;
        while (!resp_valid) begin
            if (mem_rd_req) begin
                saw_rd = 1'b1;
                if (mem_rd_addr != line_addr) begin
                    report_mismatch($sformatf("refill address %h, expected %h",
                        mem_rd_addr, line_addr));
                end
            end
            if (mem_wvalid) begin
                if (wb_count == 0) begin
                    wb_first = lat;
                end
                wb_last = lat;
                if (mem_wr_addr != victim_addr) begin
                    report_mismatch($sformatf("writeback address %h, expected %h",
                        mem_wr_addr, victim_addr));
                end
                if (mem_wdata != ref_word(victim_addr + addr_t'(4 * wb_count))) begin
                    report_mismatch($sformatf("writeback beat %0d data %h, expected %h",
                        wb_count, mem_wdata, ref_word(victim_addr + addr_t'(4 * wb_count))));
                end
                wb_count++;
            end
            @(negedge clk);
            lat++;
        end

        if (exp_hit && lat != 2) begin
            report_mismatch($sformatf("hit response after %0d cycles, expected 2", lat));
        end
        if (exp_hit && saw_rd) begin
            report_mismatch($sformatf("refill on expected hit at %h", a));
        end
        if (!exp_hit && !saw_rd) begin
            report_mismatch($sformatf("no refill on expected miss at %h", a));
        end
        if (wb_count != (exp_wb ? 8 : 0)) begin
            report_mismatch($sformatf("%0d writeback beats, expected %0d",
                wb_count, exp_wb ? 8 : 0));
        end
        if (wb_count == 8 && wb_last - wb_first != 7) begin
            report_mismatch("writeback beats not consecutive");
        end
        if (op == "L" && rdata != ref_word(wa)) begin
            report_mismatch($sformatf("load %h returned %h, expected %h",
                wa, rdata, ref_word(wa)));
        end

        // update the reference
        if (op == "S") begin
            merged = ref_word(wa);
            for (int b = 0; b < 4; b++) begin
                if (case_strb[n][b]) begin
                    merged[8*b +: 8] = case_data[n][8*b +: 8];
                end
            end
            ref_mem[wa] = merged;
        end
        if (!exp_hit) begin
            ref_tag[way][idx]   = tg;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = (op == "S");
        end
        if (op == "S" && case_strb[n] != '0) begin
            ref_dirty[way][idx] = 1'b1;
        end
        ref_lru[idx] = ~way;

        $display("case %0d: %s %h %s%s %s", n, op, a, exp_hit ? "hit" : "miss",
            exp_wb ? " writeback" : "", errors == errors_before ? "ok" : "FAIL");
    endtask

    initial begin
        arst_n = 1'b0;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        wstrb  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_lru[s] = '0;
        end
        load_cases();
        cycle_limit = 16 + 60 * case_addr.size();

        repeat (16) @(negedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (!ready || resp_valid || mem_rd_req || mem_wvalid) begin
            report_mismatch("wrong output levels after reset");
        end

        for (int n = 0; n < case_addr.size(); n++) begin
            run_case(n);
        end

        $display("cases run: %0d, failed checks: %0d", case_addr.size(), errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tests/dcache_cases.txt */
# op address strobes data, all hex after the op letter
# op L is a word load, S a store with byte strobes; loads carry 0 0
L 00000100 0 00000000
L 00000104 0 00000000
L 0000011c 0 00000000
S 00000108 3 1122aabb
L 00000108 0 00000000
S 0000010c f deadbeef
# three tags on set 2
L 00001040 0 00000000
L 00002040 0 00000000
L 00001044 0 00000000
L 00003040 0 00000000
L 00001048 0 00000000
L 00002040 0 00000000
# dirty and clean evictions on set 9
S 00005120 c 99887766
L 00006120 0 00000000
L 00007124 0 00000000
L 00005120 0 00000000
L 00007128 0 00000000
S 0000712c 1 000000ab
L 00008120 0 00000000
L 00009120 0 00000000
L 0000712c 0 00000000

/* sources.f */
design/cache_cfg_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_array_if.sv
design/dcache_ctrl.sv
design/beat_counter.sv
design/dcache_arrays.sv
design/dcache_top.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_dcache \
    --Mdir build -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/sim_dcache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
